// File: Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert
TOP        = fetch_unit_tb
FILELIST   = project.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_TEXT  = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
src/fetch_pkg.sv
src/program_memory.sv
src/fetch_aligner.sv
src/rvc_expander.sv
src/fetch_unit.sv
testbench/fetch_unit_tb.sv

// File: src/fetch_aligner.sv
module fetch_aligner (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_enable,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic [31:0] curr_word,
    input  logic [31:0] next_word,
    output logic [31:0] mem_addr,
    output logic [31:0] raw_instr,
    output logic [31:0] instr_pc,
    output logic        is_compressed,
    output logic        advance
);

    // program counter, always a halfword address
    logic [31:0] pc;
    logic [31:0] pc_next;
    // 2 for a compressed instruction, 4 otherwise
    logic [31:0] pc_step;

    // first and second halfword of the instruction at pc
    logic [15:0] low_half;
    logic [15:0] high_half;

    // word that holds the pc, the memory returns it and the one after it
    assign mem_addr = {pc[31:2], 2'b00};

    // halfword selection
    // pc[1] low means the instruction starts at the bottom of curr_word
    // pc[1] high means it starts in the top half and may run into next_word
    always_comb begin
        if (pc[1]) begin
            low_half  = curr_word[31:16];
            high_half = next_word[15:0];
        end else begin
            low_half  = curr_word[15:0];
            high_half = curr_word[31:16];
        end
    end

    // length decision, only 11 in the low bits marks a 32-bit instruction
    assign is_compressed = (low_half[1:0] != 2'b11);

    // compressed instructions go out zero extended
    // the upper half is ignored downstream anyway
    assign raw_instr = is_compressed ? {16'h0000, low_half} : {high_half, low_half};

    assign instr_pc = pc;

    // the instruction at pc is taken only when no redirect competes with it
    assign advance = fetch_enable && !redirect;

    assign pc_step = is_compressed ? 32'd2 : 32'd4;

    // redirect wins, then a normal step, otherwise hold
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (advance) begin
            pc_next = pc + pc_step;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= fetch_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // odd pc would break the halfword selection above
    a_pc_halfword_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[0] == 1'b0
    ) else $error("pc %h is not halfword aligned", pc);

    // the redirect source must hand over a legal target
    a_redirect_target_aligned: assert property (
        @(posedge clk) disable iff (reset) redirect |-> (redirect_pc[0] == 1'b0)
    ) else $error("redirect to odd address %h", redirect_pc);

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

    // program memory depth in 32-bit words, addressed by byte address bits 9:2
    localparam int mem_words = 256;

    // pc after reset
    localparam logic [31:0] reset_pc = 32'h0000_0000;

    // addi x0, x0, 0
    // this is also what an illegal compressed encoding turns into
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    // rv32i major opcodes that the expander can produce
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        load   = 7'b0000011,
        store  = 7'b0100011
    } rv_opcode_e;

    // compressed operations that the expander recognises
    typedef enum logic [4:0] {
        rvc_nop,
        rvc_addi,
        rvc_li,
        rvc_lui,
        rvc_mv,
        rvc_add,
        rvc_sub,
        rvc_and,
        rvc_or,
        rvc_xor,
        rvc_andi,
        rvc_slli,
        rvc_srli,
        rvc_srai,
        rvc_lw,
        rvc_sw,
        rvc_illegal
    } rvc_op_e;

    // load port of the program memory
    typedef struct packed {
        logic        enable;
        logic [31:0] byte_address;
        logic [31:0] data;
    } mem_write_t;

    // registered result of the fetch stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        compressed;
        logic        illegal;
    } fetch_out_t;

endpackage

// File: src/fetch_unit.sv
module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::mem_write_t  mem_write,
    input  logic                   fetch_enable,
    input  logic                   redirect,
    input  logic [31:0]            redirect_pc,
    output fetch_pkg::fetch_out_t  fetch
);

    logic [31:0] mem_addr;
    logic [31:0] curr_word;
    logic [31:0] next_word;
    logic [31:0] raw_instr;
    logic [31:0] instr_pc;
    logic        is_compressed;
    logic        advance;
    logic [31:0] expanded_instr;
    logic        illegal;

    program_memory u_program_memory (
        .clk          (clk),
        .mem_write    (mem_write),
        .byte_address (mem_addr),
        .curr_word    (curr_word),
        .next_word    (next_word)
    );

    fetch_aligner u_fetch_aligner (
        .clk           (clk),
        .reset         (reset),
        .fetch_enable  (fetch_enable),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .curr_word     (curr_word),
        .next_word     (next_word),
        .mem_addr      (mem_addr),
        .raw_instr     (raw_instr),
        .instr_pc      (instr_pc),
        .is_compressed (is_compressed),
        .advance       (advance)
    );

    rvc_expander u_rvc_expander (
        .raw_instr      (raw_instr),
        .is_compressed  (is_compressed),
        .expanded_instr (expanded_instr),
        .illegal        (illegal)
    );

    // the only pipeline stage of the front end
    // payload follows advance, valid alone is cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= advance;
        end
        if (advance) begin
            fetch.pc         <= instr_pc;
            fetch.instr      <= expanded_instr;
            fetch.compressed <= is_compressed;
            fetch.illegal    <= illegal;
        end
    end

    // illegal comes from the expander, compressed from the aligner
    a_illegal_only_compressed: assert property (
        @(posedge clk) disable iff (reset) fetch.valid |-> (!fetch.illegal || fetch.compressed)
    ) else $error("illegal flag on a 32-bit instruction at pc %h", fetch.pc);

endmodule

// File: src/program_memory.sv
module program_memory (
    input  logic                   clk,
    input  fetch_pkg::mem_write_t  mem_write,
    input  logic [31:0]            byte_address,
    output logic [31:0]            curr_word,
    output logic [31:0]            next_word
);

    // word storage, loaded through the write port before fetching starts
    logic [31:0] ram [0:fetch_pkg::mem_words-1];

    // word index of the fetch address
    logic [7:0] word_address;
    // following word, wraps from 255 back to 0
    logic [7:0] next_address;
    // word index of the write
    logic [7:0] write_address;

    assign word_address  = byte_address[9:2];
    assign next_address  = word_address + 8'd1;
    assign write_address = mem_write.byte_address[9:2];

    // synchronous write, the new word is visible right after the edge
    always_ff @(posedge clk) begin
        if (mem_write.enable) begin
            ram[write_address] <= mem_write.data;
        end
    end

    // both reads are combinational
    assign curr_word = ram[word_address];
    // upper half of a straddling 32-bit instruction comes from here
    assign next_word = ram[next_address];

    // loads are whole words, a byte offset would silently be dropped
    a_write_word_aligned: assert property (
        @(posedge clk) mem_write.enable |-> (mem_write.byte_address[1:0] == 2'b00)
    ) else $error("program memory write to unaligned address %h",
                  mem_write.byte_address);

endmodule

// File: src/rvc_expander.sv
module rvc_expander (
    input  logic [31:0] raw_instr,
    input  logic        is_compressed,
    output logic [31:0] expanded_instr,
    output logic        illegal
);

    // the 16-bit form
    logic [15:0] c;
    logic [2:0]  funct3;
    fetch_pkg::rvc_op_e rvc_op;

    // full 5-bit register fields of the CI and CR formats
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    // 3-bit register fields, x8 to x15
    logic [4:0]  rd_p;
    logic [4:0]  rs2_p;

    // rebuilt immediates
    logic [11:0] imm_ci;
    logic [19:0] imm_lui;
    logic [4:0]  shamt;
    logic [11:0] mem_off;

    assign c        = raw_instr[15:0];
    assign funct3   = c[15:13];
    assign rd_full  = c[11:7];
    assign rs2_full = c[6:2];
    assign rd_p     = {2'b01, c[9:7]};
    assign rs2_p    = {2'b01, c[4:2]};

    // 6-bit signed immediate, bit 5 sits in c[12]
    assign imm_ci   = {{6{c[12]}}, c[12], c[6:2]};
    // c.lui gives nzimm[17:12], sign extended over the upper 20 bits
    assign imm_lui  = {{14{c[12]}}, c[12], c[6:2]};
    assign shamt    = c[6:2];
    // word offset of c.lw and c.sw, uimm[5:3] c[12:10], uimm[2] c[6], uimm[6] c[5]
    assign mem_off  = {5'b00000, c[5], c[12:10], c[6], 2'b00};

    // classification by quadrant and funct fields
    always_comb begin
        rvc_op = fetch_pkg::rvc_illegal;
        case (c[1:0])
            2'b00: begin
                // all-zero halfword and c.addi4spn stay illegal
                if (funct3 == 3'b010) rvc_op = fetch_pkg::rvc_lw;
                if (funct3 == 3'b110) rvc_op = fetch_pkg::rvc_sw;
            end
            2'b01: begin
                case (funct3)
                    3'b000: rvc_op = (rd_full == 5'd0) ? fetch_pkg::rvc_nop
                                                       : fetch_pkg::rvc_addi;
                    3'b010: rvc_op = fetch_pkg::rvc_li;
                    3'b011: begin
                        // rd == x2 is c.addi16sp, not supported here
                        if (rd_full != 5'd0 && rd_full != 5'd2 && imm_ci != 12'd0) begin
                            rvc_op = fetch_pkg::rvc_lui;
                        end
                    end
                    3'b100: begin
                        case (c[11:10])
                            // shamt[5] set is reserved on rv32
                            2'b00: if (!c[12]) rvc_op = fetch_pkg::rvc_srli;
                            2'b01: if (!c[12]) rvc_op = fetch_pkg::rvc_srai;
                            2'b10: rvc_op = fetch_pkg::rvc_andi;
                            default: begin
                                if (!c[12]) begin
                                    case (c[6:5])
                                        2'b00:   rvc_op = fetch_pkg::rvc_sub;
                                        2'b01:   rvc_op = fetch_pkg::rvc_xor;
                                        2'b10:   rvc_op = fetch_pkg::rvc_or;
                                        default: rvc_op = fetch_pkg::rvc_and;
                                    endcase
                                end
                            end
                        endcase
                    end
                    default: rvc_op = fetch_pkg::rvc_illegal;
                endcase
            end
            2'b10: begin
                if (funct3 == 3'b000 && !c[12]) rvc_op = fetch_pkg::rvc_slli;
                // rs2 == 0 here would be c.jr, c.jalr or c.ebreak
                if (funct3 == 3'b100 && rs2_full != 5'd0) begin
                    rvc_op = c[12] ? fetch_pkg::rvc_add : fetch_pkg::rvc_mv;
                end
            end
            default: rvc_op = fetch_pkg::rvc_illegal;
        endcase
    end

    // rv32i assembly
    always_comb begin
        expanded_instr = fetch_pkg::nop_instr;
        if (!is_compressed) begin
            expanded_instr = raw_instr;
        end else begin
            case (rvc_op)
                fetch_pkg::rvc_addi: expanded_instr = {imm_ci, rd_full, 3'b000, rd_full,
                                                       fetch_pkg::op_imm};
                fetch_pkg::rvc_li:   expanded_instr = {imm_ci, 5'd0, 3'b000, rd_full,
                                                       fetch_pkg::op_imm};
                fetch_pkg::rvc_lui:  expanded_instr = {imm_lui, rd_full, fetch_pkg::lui};
                // c.mv is add rd, x0, rs2
                fetch_pkg::rvc_mv:   expanded_instr = {7'b0000000, rs2_full, 5'd0, 3'b000,
                                                       rd_full, fetch_pkg::op};
                fetch_pkg::rvc_add:  expanded_instr = {7'b0000000, rs2_full, rd_full, 3'b000,
                                                       rd_full, fetch_pkg::op};
                fetch_pkg::rvc_sub:  expanded_instr = {7'b0100000, rs2_p, rd_p, 3'b000,
                                                       rd_p, fetch_pkg::op};
                fetch_pkg::rvc_xor:  expanded_instr = {7'b0000000, rs2_p, rd_p, 3'b100,
                                                       rd_p, fetch_pkg::op};
                fetch_pkg::rvc_or:   expanded_instr = {7'b0000000, rs2_p, rd_p, 3'b110,
                                                       rd_p, fetch_pkg::op};
                fetch_pkg::rvc_and:  expanded_instr = {7'b0000000, rs2_p, rd_p, 3'b111,
                                                       rd_p, fetch_pkg::op};
                fetch_pkg::rvc_andi: expanded_instr = {imm_ci, rd_p, 3'b111, rd_p,
                                                       fetch_pkg::op_imm};
                fetch_pkg::rvc_slli: expanded_instr = {7'b0000000, shamt, rd_full, 3'b001,
                                                       rd_full, fetch_pkg::op_imm};
                fetch_pkg::rvc_srli: expanded_instr = {7'b0000000, shamt, rd_p, 3'b101,
                                                       rd_p, fetch_pkg::op_imm};
                fetch_pkg::rvc_srai: expanded_instr = {7'b0100000, shamt, rd_p, 3'b101,
                                                       rd_p, fetch_pkg::op_imm};
                // the loaded register sits in the rs2' field
                fetch_pkg::rvc_lw:   expanded_instr = {mem_off, rd_p, 3'b010, rs2_p,
                                                       fetch_pkg::load};
                fetch_pkg::rvc_sw:   expanded_instr = {mem_off[11:5], rs2_p, rd_p, 3'b010,
                                                       mem_off[4:0], fetch_pkg::store};
                // c.nop and everything illegal
                default:             expanded_instr = fetch_pkg::nop_instr;
            endcase
        end
    end

    assign illegal = is_compressed && (rvc_op == fetch_pkg::rvc_illegal);

endmodule

// File: testbench/fetch_unit_tb.sv
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  reset;
    fetch_pkg::mem_write_t mem_write;
    logic                  fetch_enable;
    logic                  redirect;
    logic [31:0]           redirect_pc;
    fetch_pkg::fetch_out_t fetch;

    // table of encodings with hand-written rv32i expansions
    logic [31:0] tab_enc [$];
    logic [31:0] tab_exp [$];
    bit          tab_ill [$];

    // program image and expected result, indexed by halfword address
    logic [15:0] half_img  [0:511];
    logic [31:0] ref_instr [0:511];
    bit          ref_comp  [0:511];
    bit          ref_ill   [0:511];

    logic [31:0] lcg_state = 32'hb916_bf96;
    // pc that the next valid output must carry
    logic [31:0] exp_pc;
    // fetch_enable and redirect as seen on the last rising edge
    logic        en_edge;
    logic        redir_edge;
    logic [31:0] mid_a;
    logic [31:0] end_a;
    logic [31:0] load_a;
    logic [31:0] base_b;
    logic [31:0] end_b;
    logic [31:0] load_b;
    int          errors = 0;
    int          test_errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          n_instr = 0;
    string       test_name = "setup";

    fetch_unit DUT (
        .clk          (clk),
        .reset        (reset),
        .mem_write    (mem_write),
        .fetch_enable (fetch_enable),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .fetch        (fetch)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_entry(input logic [31:0] enc, input logic [31:0] exp, input bit ill);
        tab_enc.push_back(enc);
        tab_exp.push_back(exp);
        tab_ill.push_back(ill);
    endtask

    // puts table entry idx at byte address addr, gives the address after it
    function automatic logic [31:0] place(input int idx, input logic [31:0] addr);
        logic [31:0] enc;
        bit          comp;
        enc = tab_enc[idx];
        // only 11 in the low bits marks a 32-bit instruction
        comp = (enc[1:0] != 2'b11);
        half_img[addr[9:1]]  = enc[15:0];
        ref_instr[addr[9:1]] = tab_exp[idx];
        ref_comp[addr[9:1]]  = comp;
        ref_ill[addr[9:1]]   = tab_ill[idx];
        n_instr++;
        if (comp) begin
            return addr + 32'd2;
        end else begin
            half_img[addr[9:1] + 9'd1] = enc[31:16];
            return addr + 32'd4;
        end
    endfunction

    // c.nop padding past a segment end, ends on a word boundary
    function automatic logic [31:0] pad_end(input logic [31:0] addr);
        logic [31:0] a;
        a = place(2, place(2, addr));
        if (a[1]) a = place(2, a);
        return a;
    endfunction

    task automatic build_program();
        logic [31:0] addr;
        for (int i = 0; i < 512; i++) half_img[i] = {7'h55, 9'(i)};
        add_entry(32'h0000_4529, 32'h00a0_0513, 1'b0);  // 0  c.li x10, 10
        add_entry(32'h0000_15f5, 32'hffd5_8593, 1'b0);  // 1  c.addi x11, -3
        add_entry(32'h0000_0001, 32'h0000_0013, 1'b0);  // 2  c.nop
        add_entry(32'h0000_6615, 32'h0000_5637, 1'b0);  // 3  c.lui x12, 5
        add_entry(32'h0000_86aa, 32'h00a0_06b3, 1'b0);  // 4  c.mv x13, x10
        add_entry(32'h0000_952e, 32'h00b5_0533, 1'b0);  // 5  c.add x10, x11
        add_entry(32'h0000_8c05, 32'h4094_0433, 1'b0);  // 6  c.sub x8, x9
        add_entry(32'h0000_8ca9, 32'h00a4_c4b3, 1'b0);  // 7  c.xor x9, x10
        add_entry(32'h0000_8d4d, 32'h00b5_6533, 1'b0);  // 8  c.or x10, x11
        add_entry(32'h0000_8df1, 32'h00c5_f5b3, 1'b0);  // 9  c.and x11, x12
        add_entry(32'h0000_8a1d, 32'h0076_7613, 1'b0);  // 10 c.andi x12, 7
        add_entry(32'h0000_070e, 32'h0037_1713, 1'b0);  // 11 c.slli x14, 3
        add_entry(32'h0000_8291, 32'h0046_d693, 1'b0);  // 12 c.srli x13, 4
        add_entry(32'h0000_8709, 32'h4027_5713, 1'b0);  // 13 c.srai x14, 2
        add_entry(32'h0000_4144, 32'h0045_2483, 1'b0);  // 14 c.lw x9, 4(x10)
        add_entry(32'h0000_c40c, 32'h00b4_2423, 1'b0);  // 15 c.sw x11, 8(x8)
        add_entry(32'h0000_0000, fetch_pkg::nop_instr, 1'b1);  // 16 zero halfword
        add_entry(32'h00a0_0093, 32'h00a0_0093, 1'b0);  // 17 addi x1, x0, 10
        add_entry(32'h0020_81b3, 32'h0020_81b3, 1'b0);  // 18 add x3, x1, x2
        add_entry(32'hdead_c2b7, 32'hdead_c2b7, 1'b0);  // 19 lui x5, 0xdeadc
        add_entry(32'h0011_2023, 32'h0011_2023, 1'b0);  // 20 sw x1, 0(x2)
        // segment a: aligned word, compressed, straddling word, zero halfword
        addr = place(17, fetch_pkg::reset_pc);
        addr = place(0, addr);
        addr = place(18, addr);
        addr = place(16, addr);
        // every table entry once, so each expansion is fetched at least once
        for (int k = 0; k < tab_enc.size(); k++) addr = place(k, addr);
        for (int i = 0; i < 20; i++) begin
            // the fetch pauses at this instruction
            if (i == 6) mid_a = addr;
            addr = place(int'((next_random() >> 16) % 32'd21), addr);
        end
        end_a  = addr;
        load_a = pad_end(addr);
        // segment b starts on an odd halfword with a straddling word
        base_b = 32'h100 + (((next_random() >> 16) % 32'd32) << 2) + 32'd2;
        addr = place(19, base_b);
        for (int i = 0; i < 16; i++) addr = place(int'((next_random() >> 16) % 32'd21), addr);
        end_b  = addr;
        load_b = pad_end(addr);
        cycle_limit = 2 * n_instr + 50;
    endtask

    task automatic load_words(input logic [31:0] first, input logic [31:0] last);
        logic [31:0] a;
        a = {first[31:2], 2'b00};
        while (a < last) begin
            @(negedge clk);
            mem_write.enable       = 1'b1;
            mem_write.byte_address = a;
            mem_write.data         = {half_img[a[9:1] + 9'd1], half_img[a[9:1]]};
            a = a + 32'd4;
        end
        @(negedge clk);
        mem_write.enable = 1'b0;
    endtask

    task automatic report_value(input string what, input logic [31:0] expv,
                                input logic [31:0] actv);
        errors++;
        test_errors++;
        $display("Error %s %s: expected %h actual %h", test_name, what, expv, actv);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // lets the checks of the last falling edge settle first
    task automatic end_test();
        @(posedge clk);
        tests++;
        $display("test %s done, %0d errors", test_name, test_errors);
    endtask

    task automatic end_run();
        $display("tests %0d, outputs checked %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // reference model of the pc sequence, redirect first
    always @(posedge clk) begin
        if (reset) begin
            exp_pc     <= fetch_pkg::reset_pc;
            en_edge    <= 1'b0;
            redir_edge <= 1'b0;
        end else begin
            en_edge    <= fetch_enable;
            redir_edge <= redirect;
            if (redirect) begin
                exp_pc <= redirect_pc;
            end else if (fetch.valid) begin
                exp_pc <= exp_pc + (ref_comp[exp_pc[9:1]] ? 32'd2 : 32'd4);
                checks++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            errors++;
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            end_run();
        end
    end

    // outputs are checked on the falling edge, half a cycle after they change
    chk_valid: assert property (@(negedge clk) disable iff (reset)
        fetch.valid == (en_edge && !redir_edge))
        else report_value("valid", {31'd0, en_edge && !redir_edge}, {31'd0, fetch.valid});
    chk_pc: assert property (@(negedge clk) disable iff (reset)
        fetch.valid |-> fetch.pc == exp_pc)
        else report_value("pc", exp_pc, fetch.pc);
    chk_instr: assert property (@(negedge clk) disable iff (reset)
        fetch.valid |-> fetch.instr == ref_instr[exp_pc[9:1]])
        else report_value("instr", ref_instr[exp_pc[9:1]], fetch.instr);
    chk_compressed: assert property (@(negedge clk) disable iff (reset)
        fetch.valid |-> fetch.compressed == ref_comp[exp_pc[9:1]])
        else report_value("compressed", {31'd0, ref_comp[exp_pc[9:1]]}, {31'd0, fetch.compressed});
    chk_illegal: assert property (@(negedge clk) disable iff (reset)
        fetch.valid |-> fetch.illegal == ref_ill[exp_pc[9:1]])
        else report_value("illegal", {31'd0, ref_ill[exp_pc[9:1]]}, {31'd0, fetch.illegal});

    initial begin
        reset            = 1'b1;
        mem_write        = '0;
        fetch_enable     = 1'b0;
        redirect         = 1'b0;
        redirect_pc      = 32'd0;
        build_program();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // program load with fetch_enable still low
        start_test("reset_idle");
        load_words(fetch_pkg::reset_pc, load_a);
        load_words(base_b, load_b);
        repeat (2) @(negedge clk);
        end_test();
        start_test("fetch_first_half");
        @(negedge clk);
        fetch_enable = 1'b1;
        while (exp_pc != mid_a) @(negedge clk);
        fetch_enable = 1'b0;
        end_test();
        start_test("enable_hold");
        repeat (4) @(negedge clk);
        fetch_enable = 1'b1;
        end_test();
        // redirect is raised with fetch_enable still high
        start_test("fetch_second_half");
        @(negedge clk);
        while (exp_pc != end_a) @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = base_b;
        end_test();
        start_test("redirect_segment_b");
        @(negedge clk);
        redirect = 1'b0;
        while (exp_pc != end_b) @(negedge clk);
        fetch_enable = 1'b0;
        repeat (3) @(negedge clk);
        end_test();
        end_run();
    end

endmodule
